// File: Bender.yml
package:
  name: busTop

sources:
  - verilog/busPkg.sv
  - verilog/requestQueue.sv
  - verilog/grantUnit.sv
  - verilog/busTop.sv
  - target: test
    files:
      - test/busChecker.sv
      - test/busTopTb.sv

// File: busTop.f
verilog/busPkg.sv
verilog/requestQueue.sv
verilog/grantUnit.sv
verilog/busTop.sv
test/busChecker.sv
test/busTopTb.sv

// File: test/busChecker.sv
`timescale 1ns/10ps
`default_nettype none

module busChecker (
    input  logic                  clk,
    input  logic                  rst,
    input  busPkg::requesterVec_t req,
    input  busPkg::destVec_t      dest,
    input  busPkg::receiverVec_t  free,
    input  busPkg::requesterVec_t rel,
    input  busPkg::requesterVec_t ack,
    input  busPkg::requesterVec_t grant,
    input  busPkg::receiverVec_t  recv,
    output int                    valueErrors,
    output int                    timeoutErrors
);
    import busPkg::*;

    localparam int GrantTimeout = 1500;  // Cycles from load to grant

    requesterVec_t mValid;
    destVec_t      mDest;
    int            mAge [NumRequesters];
    logic          mBusy;
    requesterId_t  mOwner;
    requesterVec_t expAck;
    requesterVec_t expGrant;
    receiverVec_t  expRecv;

    task automatic compare(input string name, input logic [15:0] expVal,
                           input logic [15:0] gotVal);
        if (expVal !== gotVal) begin
            valueErrors++;
            $display("ERR %s exp %h got %h at %0t", name, expVal, gotVal, $time);
        end
    endtask

    initial begin
        valueErrors   = 0;
        timeoutErrors = 0;
    end

    // Pre-edge values of the ports describe the cycle that just ended
    always @(posedge clk) begin
        requesterVec_t load;
        int            win;
        if (rst) begin
            mValid   = '0;
            mBusy    = 1'b0;
            mOwner   = '0;
            expAck   = '0;
            expGrant = '0;
            expRecv  = '0;
            for (int i = 0; i < NumRequesters; i++) begin
                mAge[i] = 0;
            end
        end else begin
            compare("ack", 16'(expAck), 16'(ack));
            compare("grant", 16'(expGrant), 16'(grant));
            compare("recv", 16'(expRecv), 16'(recv));

            load = req & ~mValid & ~expAck;  // Slot empty and ack already dropped
            win  = -1;
            if (!mBusy) begin
                for (int i = 0; i < NumRequesters; i++) begin
                    if (mValid[i] && (mDest[i] < NumReceivers) && free[mDest[i]]) begin
                        win = i;  // Later index outranks
                    end
                end
            end

            if (win >= 0) begin
                mValid[win] = 1'b0;
                mBusy       = 1'b1;
                mOwner      = requesterId_t'(win);
                expGrant    = requesterVec_t'(1) << win;
                expRecv     = receiverVec_t'(1) << mDest[win];
            end else if (mBusy && rel[mOwner]) begin
                mBusy    = 1'b0;
                expGrant = '0;
                expRecv  = '0;
            end

            for (int i = 0; i < NumRequesters; i++) begin
                if (load[i]) begin
                    mDest[i] = dest[i];
                    mAge[i]  = 0;
                end
            end
            mValid = mValid | load;
            expAck = load;

            for (int i = 0; i < NumRequesters; i++) begin
                if (mValid[i]) begin
                    mAge[i]++;
                    if (mAge[i] == GrantTimeout) begin
                        timeoutErrors++;
                        $display("Requester %0d was acked but not granted within %0d cycles",
                                 i, GrantTimeout);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: test/busTopTb.sv
`timescale 1ns/10ps
`default_nettype none

module busTopTb;
    import busPkg::*;

    localparam int RunCycles  = 3000;
    localparam int AckTimeout = 2000;  // Covers a wait behind a full slot

    logic          clk;
    logic          rst;
    requesterVec_t req;
    destVec_t      dest;
    receiverVec_t  free;
    requesterVec_t rel;
    requesterVec_t ack;
    requesterVec_t grant;
    receiverVec_t  recv;
    int            valueErrors;
    int            timeoutErrors;
    int            stimTimeouts;
    int            waitCnt [NumRequesters];
    int            holdCnt [NumRequesters];

    initial clk = 1'b0;
    always #2 clk = ~clk;

    busTop u_dut (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .dest  (dest),
        .free  (free),
        .rel   (rel),
        .ack   (ack),
        .grant (grant),
        .recv  (recv)
    );

    busChecker u_check (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .dest          (dest),
        .free          (free),
        .rel           (rel),
        .ack           (ack),
        .grant         (grant),
        .recv          (recv),
        .valueErrors   (valueErrors),
        .timeoutErrors (timeoutErrors)
    );

    // One falling-edge step of a single requester
    // A new request may be raised while the previous one still fills the slot
    task automatic stepRequester(input int i);
        if (req[i]) begin
            waitCnt[i]++;
            if (ack[i]) begin
                req[i] = 1'b0;
            end else if (waitCnt[i] > AckTimeout) begin
                stimTimeouts++;
                $display("Requester %0d saw no ack within %0d cycles", i, AckTimeout);
                req[i] = 1'b0;
            end
        end else if ($urandom_range(99) == 0) begin
            req[i]     = 1'b1;
            dest[i]    = receiverId_t'($urandom_range(NumReceivers - 1));
            waitCnt[i] = 0;
        end else begin
            dest[i] = receiverId_t'($urandom_range(15));  // Ignored while req is low
        end

        if (holdCnt[i] > 0) begin
            holdCnt[i]--;
            if (holdCnt[i] == 0) begin
                rel[i] = 1'b1;  // Single-cycle release
            end
        end else if (grant[i]) begin
            holdCnt[i] = $urandom_range(6, 1);
        end
    endtask

    initial begin
        int other;
        void'($urandom(32'h361bbb37));
        rst          = 1'b1;
        req          = '0;
        dest         = '0;
        free         = '1;
        rel          = '0;
        stimTimeouts = 0;
        for (int i = 0; i < NumRequesters; i++) begin
            waitCnt[i] = 0;
            holdCnt[i] = 0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int cycle = 0; cycle < RunCycles; cycle++) begin
            @(negedge clk);
            rel = '0;
            for (int i = 0; i < NumRequesters; i++) begin
                stepRequester(i);
            end
            for (int r = 0; r < NumReceivers; r++) begin
                if ($urandom_range(7) == 0) begin
                    free[r] = ~free[r];
                end
            end
            if ($urandom_range(15) == 0) begin
                other = $urandom_range(NumRequesters - 1);
                if (!grant[other]) begin
                    rel[other] = 1'b1;  // Non-owner release, must be ignored
                end
            end
        end
        @(negedge clk);

        $display("Errors: %0d value, %0d grant timeout, %0d stimulus timeout",
                 valueErrors, timeoutErrors, stimTimeouts);
        if ((valueErrors + timeoutErrors + stimTimeouts) == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/busPkg.sv
`default_nettype none

package busPkg;

    // Requester order, lowest priority first
    //   0 bank 3, 1 bank 2, 2 bank 1, 3 bank 0
    //   4 D$ odd write, 5 D$ even write, 6 D$ odd read, 7 D$ even read
    //   8 I$ odd, 9 I$ even, 10 DMA
    localparam int NumRequesters = 11;

    // Receivers are IE, IO, DE, DO, B0 to B3 and DMA, index 0 to 8
    localparam int NumReceivers = 9;

    localparam int RequesterIdWidth = 4;
    localparam int ReceiverIdWidth = 4;

    typedef logic [RequesterIdWidth-1:0] requesterId_t;
    typedef logic [ReceiverIdWidth-1:0] receiverId_t;

    // One bit per requester for req, ack, rel and grant
    typedef logic [NumRequesters-1:0] requesterVec_t;

    // One bit per receiver for free and recv
    typedef logic [NumReceivers-1:0] receiverVec_t;

    // Requested destination of each requester
    typedef receiverId_t [NumRequesters-1:0] destVec_t;

    // Selected request from the queue to the grant unit
    typedef struct packed {
        requesterId_t sender;
        receiverId_t  dest;
    } busRequest_t;

    typedef enum logic {
        Idle,
        Busy
    } grantState_t;

endpackage

`default_nettype wire

// File: verilog/busTop.sv
`timescale 1ns/10ps
`default_nettype none

module busTop (
    input  logic                  clk,
    input  logic                  rst,
    input  busPkg::requesterVec_t req,
    input  busPkg::destVec_t      dest,
    input  busPkg::receiverVec_t  free,
    input  busPkg::requesterVec_t rel,
    output busPkg::requesterVec_t ack,
    output busPkg::requesterVec_t grant,
    output busPkg::receiverVec_t  recv
);
    import busPkg::*;

    logic        reqReady;
    busRequest_t selReq;
    logic        pull;

    requestQueue u_queue (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .dest     (dest),
        .free     (free),
        .pull     (pull),
        .ack      (ack),
        .reqReady (reqReady),
        .selReq   (selReq)
    );

    // Owns the bus from pull until the sender's release
    grantUnit u_grant (
        .clk      (clk),
        .rst      (rst),
        .reqReady (reqReady),
        .selReq   (selReq),
        .rel      (rel),
        .pull     (pull),
        .grant    (grant),
        .recv     (recv)
    );

endmodule

`default_nettype wire

// File: verilog/grantUnit.sv
`timescale 1ns/10ps
`default_nettype none

module grantUnit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  reqReady,
    input  busPkg::busRequest_t   selReq,
    input  busPkg::requesterVec_t rel,
    output logic                  pull,
    output busPkg::requesterVec_t grant,
    output busPkg::receiverVec_t  recv
);
    import busPkg::*;

    grantState_t   state;
    busRequest_t   owner;
    requesterVec_t selGrant;
    receiverVec_t  selRecv;

    // Take the selected request as soon as the bus is idle
    assign pull = (state == Idle) && reqReady;

    assign selGrant = requesterVec_t'(1) << selReq.sender;
    assign selRecv  = receiverVec_t'(1) << selReq.dest;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            grant <= '0;
            recv  <= '0;
        end else begin
            unique case (state)
                Idle: begin
                    if (pull) begin
                        state <= Busy;
                        grant <= selGrant;
                        recv  <= selRecv;
                    end
                end
                Busy: begin
                    if (rel[owner.sender]) begin  // Only the owner can end the transfer
                        state <= Idle;
                        grant <= '0;
                        recv  <= '0;
                    end
                end
                default: begin
                    state <= Idle;
                    grant <= '0;
                    recv  <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pull) begin
            owner <= selReq;
        end
    end

    grantOneHot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(grant) && $onehot0(recv)
    ) else $error("grant %h or recv %h is not one-hot", grant, recv);

    // A sender always has a receiver, and the pair follows the state
    grantPairsRecv: assert property (
        @(posedge clk) disable iff (rst)
        ((|grant) == (|recv)) && ((|grant) == (state == Busy))
    ) else $error("grant %h and recv %h disagree", grant, recv);

endmodule

`default_nettype wire

// File: verilog/requestQueue.sv
`timescale 1ns/10ps
`default_nettype none

module requestQueue (
    input  logic                  clk,
    input  logic                  rst,
    input  busPkg::requesterVec_t req,
    input  busPkg::destVec_t      dest,
    input  busPkg::receiverVec_t  free,
    input  logic                  pull,
    output busPkg::requesterVec_t ack,
    output logic                  reqReady,
    output busPkg::busRequest_t   selReq
);
    import busPkg::*;

    requesterVec_t slotValid;
    destVec_t      slotDest;
    requesterVec_t load;
    requesterVec_t clear;
    requesterVec_t eligible;

    // A slot takes a new request only when it is empty
    assign load = req & ~slotValid;

    always_comb begin
        clear = '0;
        if (pull) begin
            clear[selReq.sender] = 1'b1;  // Slot taken by the grant unit
        end
    end

    always_comb begin
        for (int i = 0; i < NumRequesters; i++) begin
            eligible[i] = slotValid[i]
                          && (slotDest[i] < receiverId_t'(NumReceivers))
                          && free[slotDest[i]];
        end
    end

    // Fixed priority, the highest eligible index wins
    always_comb begin
        reqReady = 1'b0;
        selReq   = '0;
        for (int i = 0; i < NumRequesters; i++) begin
            if (eligible[i]) begin
                reqReady      = 1'b1;
                selReq.sender = requesterId_t'(i);
                selReq.dest   = slotDest[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slotValid <= '0;
            ack       <= '0;
        end else begin
            slotValid <= (slotValid | load) & ~clear;
            ack       <= load;  // One cycle after the load
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NumRequesters; i++) begin
            if (load[i]) begin
                slotDest[i] <= dest[i];
            end
        end
    end

    // The grant unit may only pull while a request is eligible
    pullNeedsReady: assert property (
        @(posedge clk) disable iff (rst)
        pull |-> reqReady
    ) else $error("pull without an eligible request");

    for (genvar g = 0; g < NumRequesters; g++) begin : gDestCheck
        destInRange: assert property (
            @(posedge clk) disable iff (rst)
            load[g] |=> (slotDest[g] < receiverId_t'(NumReceivers))
        ) else $error("requester %0d loaded destination %0d", g, slotDest[g]);
    end

endmodule

`default_nettype wire
